// ==== Makefile ====
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(BUILD)"

test:
	verilator --binary --timing --assert --top-module tb_readout -f readout.f -Mdir $(BUILD)
	./$(BUILD)/Vtb_readout +verilator+error+limit+1000 | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD)

// ==== hdl/burst_serializer.sv ====
`timescale 1ns/1ps
`include "readout_macros.svh"

module burst_serializer (
  input  logic             clk125,
  input  logic             arst_n,
  readout_stream_if.sink   fill_s,  // 128-bit bursts in
  readout_stream_if.source word_s   // 32-bit words out
);

  localparam logic [1:0] LAST_IDX = 2'(`WORDS_PER_BURST - 1);  // index of word four

  logic [`BURST_W-1:0] burst_buf;  // burst being sent
  logic                burst_lst;  // it closes the fill
  logic                buf_full;   // burst_buf holds words still due
  logic [1:0]          word_idx;   // 0 = most significant word
  logic                word_xfer;
  logic                last_word;

  assign last_word    = (word_idx == LAST_IDX);
  assign word_xfer    = word_s.valid & word_s.ready;
  assign fill_s.ready = ~buf_full | (word_xfer & last_word);  // reload as word four leaves

  assign word_s.valid = buf_full;
  assign word_s.data  = burst_buf[(LAST_IDX - word_idx) * `WORD_W +: `WORD_W];  // msw first
  assign word_s.last  = burst_lst & last_word;

  ////////////////////////////////////////
  // word sequencing
  ////////////////////////////////////////
  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      buf_full <= 1'b0;
      word_idx <= '0;
    end else if (fill_s.valid & fill_s.ready) begin
      buf_full <= 1'b1;  // new burst, restart at word 0
      word_idx <= '0;
    end else if (word_xfer) begin
      if (last_word) begin
        buf_full <= 1'b0;  // nothing behind it
      end
      word_idx <= word_idx + 1'b1;  // wraps to 0 after word four
    end
  end

  always_ff @(posedge clk125) begin
    if (fill_s.valid & fill_s.ready) begin
      burst_buf <= fill_s.data;
      burst_lst <= fill_s.last;
    end
  end

endmodule

// ==== hdl/fill_framer.sv ====
`timescale 1ns/1ps
`include "readout_macros.svh"

module fill_framer
  import readout_pkg::*;
(
  input  logic                   clk125,
  input  logic                   arst_n,
  input  logic                   burst_valid,          // burst offered
  input  logic                   burst_is_hdr,         // burst is a fill header
  input  fill_burst_u            burst_data,
  output logic                   burst_ready,          // room in the output register
  input  logic [`FILL_NUM_W-1:0] initial_fill_num,     // first fill number to expect
  input  logic                   initial_fill_num_wr,  // load strobe for it
  output logic                   fill_seq_err,         // header out of sequence
  output logic                   adc_ovr_seen,         // forwarded burst had over-range
  readout_stream_if.source       fill_s                // 128-bit bursts to the serializer
);

  logic [`FILL_NUM_W-1:0]  fill_expect;  // next fill number in sequence
  logic [`BURST_CNT_W-1:0] bursts_left;  // data bursts still due in this fill
  logic                    take;         // burst accepted this edge
  logic                    take_hdr;
  logic                    take_dat;     // accepted and forwarded
  logic                    ovr_any;      // any slot over-range

  assign burst_ready = ~fill_s.valid | fill_s.ready;  // empty or draining
  assign take        = burst_valid & burst_ready;
  assign take_hdr    = take & burst_is_hdr;
  assign take_dat    = take & ~burst_is_hdr & (bursts_left != '0);  // no open fill, dropped

  always_comb begin
    ovr_any = 1'b0;
    for (int i = 0; i < `SAMPLES_PER_BURST; i++) begin
      ovr_any |= burst_data.adc.slot[i].ovr;  // or of the eight flags
    end
  end

  ////////////////////////////////////////
  // control and strobes
  ////////////////////////////////////////
  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      fill_s.valid <= 1'b0;
      fill_seq_err <= 1'b0;
      adc_ovr_seen <= 1'b0;
      fill_expect  <= '0;
      bursts_left  <= '0;
    end else begin
      fill_seq_err <= 1'b0;  // one-cycle strobes
      adc_ovr_seen <= 1'b0;
      if (fill_s.ready) begin
        fill_s.valid <= 1'b0;  // drained unless refilled below
      end
      if (take_hdr) begin
        fill_seq_err <= (burst_data.hdr.fill_num != fill_expect);
        bursts_left  <= burst_data.hdr.num_bursts;  // zero opens nothing
        fill_expect  <= burst_data.hdr.fill_num + 1'b1;  // resync on a skip
      end
      if (take_dat) begin
        fill_s.valid <= 1'b1;
        adc_ovr_seen <= ovr_any;
        bursts_left  <= bursts_left - 1'b1;
      end
      if (initial_fill_num_wr) begin
        fill_expect <= initial_fill_num;  // host write wins
      end
    end
  end

  // payload register
  always_ff @(posedge clk125) begin
    if (take_dat) begin
      fill_s.data <= burst_data;
      fill_s.last <= (bursts_left == 1);  // final burst of the fill
    end
  end

endmodule

// ==== hdl/link_tx_mux.sv ====
`timescale 1ns/1ps
`include "readout_macros.svh"

module link_tx_mux (
  input  logic              clk125,
  input  logic              arst_n,
  input  logic              readout_pause,  // async, high holds the link
  input  logic              cmd_valid,      // command processor packet
  input  logic [`WORD_W-1:0] cmd_data,
  input  logic              cmd_last,
  output logic              cmd_ready,
  readout_stream_if.sink    word_s,         // fill words
  output logic              tx_valid,       // to the link transmitter
  output logic [`WORD_W-1:0] tx_data,
  output logic              tx_last,
  input  logic              tx_ready,
  output logic              fill_active     // link owned by the fill
);

  logic [`SYNC_STAGES-1:0] pause_sync;   // synchronizer chain
  logic                    paused;       // pause in force
  logic                    sel_fill;     // 0 = command source
  logic                    cmd_open;     // command packet mid-flight
  logic                    cmd_open_nxt;
  logic                    cmd_xfer;
  logic                    fill_xfer;

  assign paused = pause_sync[`SYNC_STAGES-1];

  ////////////////////////////////////////
  // 2:1 select, ready only to the owner
  ////////////////////////////////////////
  assign tx_valid     = ~paused & (sel_fill ? word_s.valid : cmd_valid);
  assign tx_data      = sel_fill ? word_s.data : cmd_data;
  assign tx_last      = sel_fill ? word_s.last : cmd_last;
  assign word_s.ready = sel_fill & tx_ready & ~paused;
  assign cmd_ready    = ~sel_fill & tx_ready & ~paused;

  assign cmd_xfer     = cmd_valid & cmd_ready;
  assign fill_xfer    = word_s.valid & word_s.ready;
  assign cmd_open_nxt = cmd_xfer ? ~cmd_last : cmd_open;  // open after a non-last word
  assign fill_active  = sel_fill;

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      pause_sync <= '0;  // reads as running
      cmd_open   <= 1'b0;
      sel_fill   <= 1'b0;  // command source after reset
    end else begin
      pause_sync <= {pause_sync[`SYNC_STAGES-2:0], readout_pause};
      cmd_open   <= cmd_open_nxt;
      if (!sel_fill && word_s.valid && !cmd_open_nxt) begin
        sel_fill <= 1'b1;  // grab the link between command packets
      end else if (fill_xfer && word_s.last) begin
        sel_fill <= 1'b0;  // fill done, hand back
      end
    end
  end

endmodule

// ==== hdl/readout_macros.svh ====
`ifndef READOUT_MACROS_SVH
`define READOUT_MACROS_SVH

////////////////////////////////////////
// stream widths
////////////////////////////////////////
`define BURST_W           128  // one memory burst, header or samples
`define WORD_W            32   // one link word
`define WORDS_PER_BURST   4    // link words per burst

////////////////////////////////////////
// header fields
////////////////////////////////////////
`define FILL_NUM_W        24   // fill number
`define BURST_CNT_W       23   // data bursts in one fill

////////////////////////////////////////
// sample layout and sync depth
////////////////////////////////////////
`define SAMPLE_W          12   // adc sample bits
`define SAMPLES_PER_BURST 8    // 16-bit slots in one burst
`define SYNC_STAGES       2    // flops on the pause input

`endif

// ==== hdl/readout_pkg.sv ====
`include "readout_macros.svh"

package readout_pkg;

  ////////////////////////////////////////
  // header view of a burst
  ////////////////////////////////////////
  typedef struct packed {
    logic [`FILL_NUM_W-1:0]  fill_num;      // sequence number of the fill
    logic [11:0]             channel_tag;   // channel id bits
    logic [`BURST_CNT_W-1:0] num_bursts;    // data bursts that follow
    logic [22:0]             waveform_num;  // waveform counter
    logic [45:0]             reserved;      // spare
  } fill_hdr_t;

  ////////////////////////////////////////
  // data view of a burst
  ////////////////////////////////////////
  typedef struct packed {
    logic                           ovr;     // adc over-range at this sample
    logic [16-`SAMPLE_W-2:0]        rsv;     // pad to 16 bits
    logic [`SAMPLE_W-1:0]           sample;  // raw adc code
  } adc_slot_t;

  typedef struct packed {
    adc_slot_t [`SAMPLES_PER_BURST-1:0] slot;  // slot 7 in the top bits
  } adc_bursts_t;

  // same 128 bits, read as header or as samples
  typedef union packed {
    fill_hdr_t   hdr;
    adc_bursts_t adc;
  } fill_burst_u;

endpackage

// ==== hdl/readout_stream_if.sv ====
`timescale 1ns/1ps

// valid/ready stream, one word per transfer
interface readout_stream_if #(
  parameter int DATA_W = 32  // payload width
);

  logic              valid;  // source has a word
  logic              ready;  // sink takes it this edge
  logic              last;   // final word of a packet
  logic [DATA_W-1:0] data;   // payload

  modport source (
    output valid, last, data,
    input  ready
  );

  modport sink (
    input  valid, last, data,
    output ready
  );

endinterface

// ==== hdl/readout_top.sv ====
`timescale 1ns/1ps
`include "readout_macros.svh"

module readout_top (
  input  logic                   clk125,
  input  logic                   arst_n,
  // memory bursts
  input  logic                   burst_valid,
  input  logic [`BURST_W-1:0]    burst_data,
  input  logic                   burst_is_hdr,         // header flag
  output logic                   burst_ready,
  // command processor packets
  input  logic                   cmd_valid,
  input  logic [`WORD_W-1:0]     cmd_data,
  input  logic                   cmd_last,
  output logic                   cmd_ready,
  // control
  input  logic                   readout_pause,        // async from the master
  input  logic [`FILL_NUM_W-1:0] initial_fill_num,
  input  logic                   initial_fill_num_wr,
  // link
  output logic                   tx_valid,
  output logic [`WORD_W-1:0]     tx_data,
  output logic                   tx_last,
  input  logic                   tx_ready,
  // status
  output logic                   fill_seq_err,
  output logic                   adc_ovr_seen,
  output logic                   fill_active
);

  readout_stream_if #(.DATA_W(`BURST_W)) fill_s ();  // framer to serializer
  readout_stream_if #(.DATA_W(`WORD_W))  word_s ();  // serializer to mux

  fill_framer fill_framer_inst (
    .clk125              (clk125),
    .arst_n              (arst_n),
    .burst_valid         (burst_valid),
    .burst_is_hdr        (burst_is_hdr),
    .burst_data          (burst_data),
    .burst_ready         (burst_ready),
    .initial_fill_num    (initial_fill_num),
    .initial_fill_num_wr (initial_fill_num_wr),
    .fill_seq_err        (fill_seq_err),
    .adc_ovr_seen        (adc_ovr_seen),
    .fill_s              (fill_s.source)
  );

  burst_serializer burst_serializer_inst (
    .clk125 (clk125),
    .arst_n (arst_n),
    .fill_s (fill_s.sink),
    .word_s (word_s.source)
  );

  link_tx_mux link_tx_mux_inst (
    .clk125        (clk125),
    .arst_n        (arst_n),
    .readout_pause (readout_pause),
    .cmd_valid     (cmd_valid),
    .cmd_data      (cmd_data),
    .cmd_last      (cmd_last),
    .cmd_ready     (cmd_ready),
    .word_s        (word_s.sink),
    .tx_valid      (tx_valid),
    .tx_data       (tx_data),
    .tx_last       (tx_last),
    .tx_ready      (tx_ready),
    .fill_active   (fill_active)
  );

endmodule

// ==== readout.f ====
+incdir+hdl
hdl/readout_pkg.sv
hdl/readout_stream_if.sv
hdl/fill_framer.sv
hdl/burst_serializer.sv
hdl/link_tx_mux.sv
hdl/readout_top.sv
testbench/readout_scoreboard.sv
testbench/readout_chk.sv
testbench/tb_readout.sv

// ==== testbench/readout_chk.sv ====
`timescale 1ns/1ps
`include "readout_macros.svh"

// handshake and pause rules of the link mux
module readout_chk (
  input logic        clk125,
  input logic        arst_n,
  input logic        s_valid,    // fill word stream into the mux
  input logic        s_ready,
  input logic        s_last,
  input logic [31:0] s_data,
  input logic        tx_valid,
  input logic        pause_in,   // raw pause input of the top level
  input logic        cmd_ready   // command side ready
);

  int   fails = 0;  // failed assertions so far
  logic pkt_open;   // fill packet between its first and last word

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      pkt_open <= 1'b0;
    end else if (s_valid && s_ready) begin
      pkt_open <= !s_last;  // closes on the last word
    end
  end

  a_hold : assert property (@(posedge clk125) disable iff (!arst_n)
    (s_valid && !s_ready) |=> (s_valid && $stable(s_data) && $stable(s_last)))
    else begin
      fails++;
      $error("word stream dropped or changed a word while waiting for ready");
    end

  a_pause : assert property (@(posedge clk125) disable iff (!arst_n)
    $past(pause_in, `SYNC_STAGES) |-> (!tx_valid && !s_ready && !cmd_ready))
    else begin
      fails++;
      $error("tx_valid or a ready high while the pause is in force");
    end

  a_ready : assert property (@(posedge clk125) disable iff (!arst_n)
    pkt_open |-> !cmd_ready)
    else begin
      fails++;
      $error("command side saw ready inside a fill packet");
    end

endmodule

bind link_tx_mux readout_chk readout_chk_inst (
  .clk125    (clk125),
  .arst_n    (arst_n),
  .s_valid   (word_s.valid),
  .s_ready   (word_s.ready),
  .s_last    (word_s.last),
  .s_data    (word_s.data),
  .tx_valid  (tx_valid),
  .pause_in  (readout_pause),
  .cmd_ready (cmd_ready)
);

// ==== testbench/readout_scoreboard.sv ====
`timescale 1ns/1ps
`include "readout_macros.svh"

module readout_scoreboard
  import readout_pkg::*;
(
  input logic                clk125,
  input logic                arst_n,
  input logic                burst_valid,
  input logic                burst_ready,
  input logic                burst_is_hdr,
  input logic [`BURST_W-1:0] burst_data,
  input logic                exp_err,       // table value for this burst
  input logic                exp_ovr,
  input logic                cmd_valid,
  input logic                cmd_ready,
  input logic [`WORD_W-1:0]  cmd_data,
  input logic                cmd_last,
  input logic                tx_valid,
  input logic                tx_ready,
  input logic [`WORD_W-1:0]  tx_data,
  input logic                tx_last,
  input logic                fill_seq_err,
  input logic                adc_ovr_seen,
  input logic                fill_active
);

  int          errors = 0;
  logic [32:0] fill_q[$];  // {last, word} still due on tx
  logic [32:0] head;
  int          left;       // data bursts due in the open fill
  logic        pend, perr, povr;  // strobes due next cycle
  logic        cmd_open, fill_open;
  fill_burst_u b;

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    errors++;
    $display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
  endtask

  always @(posedge clk125) begin
    if (!arst_n) begin
      left      = 0;
      pend      = 0;
      perr      = 0;
      povr      = 0;
      cmd_open  = 0;
      fill_open = 0;
    end else begin
      ////////////////////////////////////////
      // strobes one cycle after acceptance
      ////////////////////////////////////////
      if (fill_seq_err !== (pend & perr)) begin
        report_mismatch("fill_seq_err", 32'(pend & perr), 32'(fill_seq_err));
      end
      if (adc_ovr_seen !== (pend & povr)) begin
        report_mismatch("adc_ovr_seen", 32'(pend & povr), 32'(adc_ovr_seen));
      end
      pend = burst_valid & burst_ready;
      perr = exp_err;
      povr = exp_ovr;
      if (pend) begin
        b = burst_data;
        if (burst_is_hdr) begin
          left = int'(b.hdr.num_bursts);  // zero opens no fill
        end else if (left > 0) begin
          for (int w = 0; w < `WORDS_PER_BURST; w++)
            fill_q.push_back({(left == 1) && (w == `WORDS_PER_BURST - 1),
                              burst_data[`BURST_W-1-w*`WORD_W -: `WORD_W]});  // msw first
          left--;
        end
      end
      ////////////////////////////////////////
      // link words
      ////////////////////////////////////////
      if (fill_open && fill_active !== 1'b1) begin
        report_mismatch("fill_active", 32'd1, 32'(fill_active));  // held through stalls
      end
      if (tx_valid && tx_ready) begin
        if (cmd_valid && cmd_ready) begin
          if (fill_open) begin
            errors++;
            $display("command word sent in the middle of a fill packet at %0t", $time);
          end
          if (tx_data !== cmd_data) report_mismatch("tx_data", cmd_data, tx_data);
          if (tx_last !== cmd_last) report_mismatch("tx_last", 32'(cmd_last), 32'(tx_last));
          cmd_open = !cmd_last;
        end else if (fill_q.size() == 0) begin
          errors++;
          $display("fill word on tx with none expected at %0t", $time);
        end else begin
          if (cmd_open) begin
            errors++;
            $display("fill word sent in the middle of a command packet at %0t", $time);
          end
          head = fill_q.pop_front();
          if (tx_data !== head[31:0]) report_mismatch("tx_data", head[31:0], tx_data);
          if (tx_last !== head[32]) report_mismatch("tx_last", 32'(head[32]), 32'(tx_last));
          if (!fill_open && fill_active !== 1'b1) begin
            report_mismatch("fill_active", 32'd1, 32'(fill_active));  // first word of the fill
          end
          fill_open = !head[32];
        end
      end
    end
  end

endmodule

// ==== testbench/tb_readout.sv ====
`timescale 1ns/1ps
`include "readout_macros.svh"

module tb_readout
  import readout_pkg::*;
();

  localparam logic [31:0] SEED = 32'h8970c060;

  logic clk125 = 0, arst_n = 0;
  logic burst_valid = 0, burst_is_hdr = 0, burst_ready;
  logic [`BURST_W-1:0] burst_data = '0;
  logic cmd_valid = 0, cmd_last = 0, cmd_ready;
  logic [`WORD_W-1:0] cmd_data = '0, tx_data;
  logic readout_pause = 0, initial_fill_num_wr = 0, tx_ready = 1;
  logic [`FILL_NUM_W-1:0] initial_fill_num = '0;
  logic tx_valid, tx_last, fill_seq_err, adc_ovr_seen, fill_active;
  logic exp_err = 0, exp_ovr = 0;

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////
  logic [`BURST_W-1:0] t_data[32];
  bit   t_hdr[32], t_err[32], t_ovr[32];
  int   t_act[32];  // action code applied before the entry
  int   n_ent = 0, cycles = 0, limit = 0, total;
  logic [31:0] rnd = SEED, rnd_stall = SEED;
  bit   stall_en = 0, cmd_busy = 0, pause_busy = 0;

  always #2 clk125 = ~clk125;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic add_hdr(input logic [`FILL_NUM_W-1:0] fnum,
                         input logic [`BURST_CNT_W-1:0] nb,
                         input bit err, input int act);
    fill_hdr_t h;
    h = '0;
    h.fill_num = fnum;
    h.num_bursts = nb;
    rnd = xorshift(rnd);
    h.channel_tag = rnd[11:0];
    t_data[n_ent] = h;
    t_hdr[n_ent]  = 1;
    t_err[n_ent]  = err;
    t_ovr[n_ent]  = 0;
    t_act[n_ent]  = act;
    n_ent++;
  endtask

  task automatic add_dat(input logic [7:0] ovr_mask, input bit ovr);
    adc_bursts_t d;
    for (int s = 0; s < `SAMPLES_PER_BURST; s++) begin
      rnd = xorshift(rnd);
      d.slot[s] = {ovr_mask[s], 3'b000, rnd[`SAMPLE_W-1:0]};  // random adc code
    end
    t_data[n_ent] = d;
    t_hdr[n_ent]  = 0;
    t_err[n_ent]  = 0;
    t_ovr[n_ent]  = ovr;
    t_act[n_ent]  = 0;
    n_ent++;
  endtask

  // one command packet with a ready wait per word
  task automatic send_cmd(input int n, input logic [31:0] base);
    cmd_busy = 1;
    for (int k = 0; k < n; k++) begin
      cmd_valid <= 1;
      cmd_data  <= base + k;
      cmd_last  <= (k == n - 1);
      do @(posedge clk125); while (!cmd_ready);
    end
    cmd_valid <= 0;
    cmd_busy = 0;
  endtask

  task automatic hold_pause();
    pause_busy = 1;
    repeat (6) @(posedge clk125);
    readout_pause <= 1;
    repeat (30) @(posedge clk125);
    readout_pause <= 0;
    repeat (4) @(posedge clk125);  // let the synchronizer release
    pause_busy = 0;
  endtask

  readout_top readout_top_inst (.*);

  readout_scoreboard scoreboard_inst (.*);

  always @(posedge clk125) begin
    if (stall_en) begin
      rnd_stall = xorshift(rnd_stall);
      tx_ready <= (rnd_stall[1:0] != 2'b00);  // ready three cycles in four
    end else begin
      tx_ready <= 1;
    end
  end

  always @(posedge clk125) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles with %0d fill words undelivered",
               cycles, scoreboard_inst.fill_q.size());
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    add_hdr(5, 2, 0, 1);
    add_dat(8'h00, 0);
    add_dat(8'h04, 1);
    add_hdr(6, 3, 0, 1);
    add_dat(8'h00, 0);
    add_dat(8'h81, 1);
    add_dat(8'h00, 0);
    add_hdr(8, 1, 1, 2);  // fill 7 skipped
    add_dat(8'h00, 0);
    add_hdr(9, 2, 0, 3);
    add_dat(8'h10, 1);
    add_dat(8'h00, 0);
    add_hdr(10, 0, 0, 0);  // empty fill
    add_dat(8'hff, 0);     // stray burst is dropped
    add_hdr(11, 2, 0, 1);
    add_dat(8'h00, 0);
    add_dat(8'h00, 0);
    limit = 20 * n_ent * `WORDS_PER_BURST;

    repeat (3) @(posedge clk125);
    arst_n <= 1;
    @(posedge clk125);
    initial_fill_num    <= 5;
    initial_fill_num_wr <= 1;
    @(posedge clk125);
    initial_fill_num_wr <= 0;
    @(posedge clk125);

    for (int i = 0; i < n_ent; i++) begin
      case (t_act[i])
        1: send_cmd(3, 32'hc0de_0000 + (i << 8));  // packet ahead of the header
        2: fork send_cmd(6, 32'hc0de_8000); join_none  // packet racing the fill
        3: fork hold_pause(); join_none  // pause during the fill
        default: ;
      endcase
      if (i == 3) stall_en = 1;
      burst_valid  <= 1;
      burst_is_hdr <= t_hdr[i];
      burst_data   <= t_data[i];
      exp_err      <= t_err[i];
      exp_ovr      <= t_ovr[i];
      do @(posedge clk125); while (!burst_ready);
    end
    burst_valid <= 0;
    exp_err     <= 0;
    exp_ovr     <= 0;

    while (scoreboard_inst.fill_q.size() != 0 || cmd_busy || pause_busy) @(posedge clk125);
    repeat (5) @(posedge clk125);

    total = scoreboard_inst.errors + readout_top_inst.link_tx_mux_inst.readout_chk_inst.fails;
    $display("errors: scoreboard %0d, assertions %0d",
             scoreboard_inst.errors, readout_top_inst.link_tx_mux_inst.readout_chk_inst.fails);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
